// ==== hw/bpred_macros.svh ====
/*
 * Shared constants for the branch prediction front end.
 * Include wherever the reset PC or the BTB geometry is needed.
 * The history width is fixed here because the testbench model reuses the frame layout.
 */
`ifndef BPRED_MACROS_SVH
`define BPRED_MACROS_SVH

// first fetch address out of reset
`define BPRED_RESET_PC 32'h0000_0200

// btb geometry, 2-way over 32 frames gives 16 sets
`define BTB_N_FRAMES 32
`define BTB_ASSOC 2
`define BTB_SET_BITS 4 // set index from pc[5:2]

// taken history per frame, prediction is the top bit
`define BTB_PRED_BITS 2

// tag and history share one byte per frame
`define BTB_TAG_BITS (8 - `BTB_PRED_BITS)

`endif

// ==== hw/bpred_pkg.sv ====
/*
 * Types shared by the fetch PC generator, the BTB and the branch resolver.
 * Modules import it inside their bodies and use scoped names on their ports.
 */
`include "bpred_macros.svh"

package bpred_pkg;

	// fetch pc, branch targets
	typedef logic [31:0] word_t;

	// upper pc slice stored per frame
	typedef logic [`BTB_TAG_BITS-1:0] btb_tag_t;

	// selects one set of the btb
	typedef logic [`BTB_SET_BITS-1:0] btb_idx_t;

	// shift history of taken outcomes
	// newest outcome enters at bit 0
	typedef logic [`BTB_PRED_BITS-1:0] btb_hist_t;

	// saturates at all ones
	typedef logic [15:0] mispredict_cnt_t;

	// resolver record holding states
	typedef enum logic {
		IDLE,   // nothing registered
		UPDATE  // record drives update and maybe redirect
	} resolver_state_e;

endpackage

// ==== hw/fetch_pc_gen.sv ====
/*
 * Fetch PC register for the prediction front end.
 * Follows the BTB next-PC on each fetch strobe; a resolver redirect replaces
 * the path and wins over fetch_en in the same cycle.
 */
`timescale 1ns/1ps
`include "bpred_macros.svh"

module fetch_pc_gen (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              fetch_en,        // one fetch this cycle
	input  bpred_pkg::word_t  target_addr,     // btb predicted next pc
	input  logic              redirect_valid,  // mispredict correction
	input  bpred_pkg::word_t  redirect_pc,
	output bpred_pkg::word_t  fetch_pc,
	output logic              fetch_valid
);
	import bpred_pkg::*;

	word_t next_pc;   // pc for the coming edge
	logic  pc_load;   // register enable

	// fetch only counts when nothing is being corrected
	assign fetch_valid = fetch_en & ~redirect_valid;

	// redirect has priority over the predicted path
	always_comb begin
		next_pc = fetch_pc; // hold by default
		pc_load = 1'b0;
		if (redirect_valid) begin
			next_pc = redirect_pc;
			pc_load = 1'b1;
		end else if (fetch_en) begin
			next_pc = target_addr; // taken target or fallthrough
			pc_load = 1'b1;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fetch_pc <= `BPRED_RESET_PC;
		end else if (pc_load) begin
			fetch_pc <= next_pc;
		end
	end

	// targets come from the btb and from execute, both must keep
	// the pc on a halfword boundary for rv32c
	a_pc_halfword: assert property (
		@(posedge CLK) disable iff (!nRST)
		fetch_pc[0] == 1'b0
	) else $error("fetch_pc not halfword aligned: %h", fetch_pc);

endmodule

// ==== hw/btb.sv ====
/*
 * 2-way set-associative branch target buffer, 16 sets.
 * Each frame holds a tag, a target and a short taken history.
 * Lookup from fetch_pc is combinational; updates from the resolver land on
 * the next edge, frame 0 when it matches or is empty, else frame 1.
 */
`timescale 1ns/1ps
`include "bpred_macros.svh"

module btb (
	input  logic              CLK,
	input  logic              nRST,
	// lookup side
	input  bpred_pkg::word_t  fetch_pc,
	input  logic              is_branch,     // decode hint for fetch_pc
	input  logic              is_rv32c,      // 2-byte instruction
	output logic              predict_taken,
	output bpred_pkg::word_t  target_addr,   // next fetch pc
	// training side
	input  logic              update_valid,
	input  bpred_pkg::word_t  update_pc,
	input  logic              update_taken,
	input  bpred_pkg::word_t  update_target
);
	import bpred_pkg::*;

	localparam int N_SETS  = `BTB_N_FRAMES / `BTB_ASSOC;
	localparam int IDX_LSB = 2;                        // skip byte offset
	localparam int TAG_LSB = IDX_LSB + `BTB_SET_BITS;  // tag right above index

	// frame storage, one entry per set and way
	btb_tag_t  tag_mem    [N_SETS][`BTB_ASSOC];
	word_t     target_mem [N_SETS][`BTB_ASSOC];
	btb_hist_t hist_mem   [N_SETS][`BTB_ASSOC];

	// lookup decode
	btb_tag_t  fetch_tag;
	btb_idx_t  fetch_idx;
	logic      hit0, hit1;
	logic      fetch_hit;
	logic      sel_way;     // way chosen for the prediction
	word_t     sel_target;
	btb_hist_t sel_hist;
	word_t     fallthrough;

	// update decode
	btb_tag_t  upd_tag;
	btb_idx_t  upd_idx;
	logic      upd_way;     // way to overwrite
	btb_hist_t hist_next;

	assign fetch_tag = fetch_pc[TAG_LSB +: `BTB_TAG_BITS];
	assign fetch_idx = fetch_pc[IDX_LSB +: `BTB_SET_BITS];

	// no valid bit, a cleared frame hits tag 0 but predicts not taken
	assign hit0      = (tag_mem[fetch_idx][0] == fetch_tag);
	assign hit1      = (tag_mem[fetch_idx][1] == fetch_tag);
	assign fetch_hit = hit0 | hit1;
	assign sel_way   = hit0 ? 1'b0 : 1'b1;  // frame 0 wins on double hit

	assign sel_target = target_mem[fetch_idx][sel_way];
	assign sel_hist   = hist_mem[fetch_idx][sel_way];

	assign fallthrough = is_rv32c ? fetch_pc + 32'd2 : fetch_pc + 32'd4;

	// only a known branch with top history bit set goes taken
	always_comb begin
		predict_taken = fetch_hit & is_branch & sel_hist[`BTB_PRED_BITS-1];
		target_addr   = predict_taken ? sel_target : fallthrough;
	end

	assign upd_tag = update_pc[TAG_LSB +: `BTB_TAG_BITS];
	assign upd_idx = update_pc[IDX_LSB +: `BTB_SET_BITS];

	// replacement: frame 0 on tag match or zero target, else frame 1
	always_comb begin
		if (tag_mem[upd_idx][0] == upd_tag || target_mem[upd_idx][0] == '0) begin
			upd_way = 1'b0;
		end else begin
			upd_way = 1'b1;
		end
	end

	// shift new outcome in at bit 0, oldest drops off the top
	assign hist_next = btb_hist_t'({hist_mem[upd_idx][upd_way], update_taken});

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < N_SETS; s++) begin
				for (int w = 0; w < `BTB_ASSOC; w++) begin
					tag_mem[s][w]    <= '0;
					target_mem[s][w] <= '0;
					hist_mem[s][w]   <= '0;
				end
			end
		end else if (update_valid) begin
			tag_mem[upd_idx][upd_way]    <= upd_tag;
			target_mem[upd_idx][upd_way] <= update_target; // stored even if not taken
			hist_mem[upd_idx][upd_way]   <= hist_next;
		end
	end

	// a zero target reads as an empty frame 0 and would be overwritten
	a_taken_target_nonzero: assert property (
		@(posedge CLK) disable iff (!nRST)
		(update_valid && update_taken) |-> (update_target != '0)
	) else $error("taken update with zero target, pc %h", update_pc);

endmodule

// ==== hw/branch_resolver.sv ====
/*
 * Takes resolved branches from execute, registers them for one cycle and
 * then trains the BTB. A wrong prediction also raises a redirect with the
 * corrected fetch PC and bumps a saturating mispredict counter.
 */
`timescale 1ns/1ps

module branch_resolver (
	input  logic                        CLK,
	input  logic                        nRST,
	// from execute
	input  logic                        resolve_valid,
	input  bpred_pkg::word_t            resolve_pc,
	input  logic                        resolve_taken,
	input  bpred_pkg::word_t            resolve_target,
	input  logic                        resolve_rv32c,
	input  logic                        resolve_pred_taken, // guess made at fetch
	// btb training
	output logic                        update_valid,
	output bpred_pkg::word_t            update_pc,
	output logic                        update_taken,
	output bpred_pkg::word_t            update_target,
	// fetch correction
	output logic                        redirect_valid,
	output bpred_pkg::word_t            redirect_pc,
	output bpred_pkg::mispredict_cnt_t  mispredict_count
);
	import bpred_pkg::*;

	resolver_state_e state, next_state;

	// registered resolve record
	word_t rec_pc;
	word_t rec_target;
	logic  rec_taken;
	logic  rec_rv32c;
	logic  rec_mispred;

	// one record per cycle, a new resolve keeps us in UPDATE
	always_comb begin
		next_state = resolve_valid ? UPDATE : IDLE;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// payload only, qualified by state
	always_ff @(posedge CLK) begin
		if (resolve_valid) begin
			rec_pc      <= resolve_pc;
			rec_target  <= resolve_target;
			rec_taken   <= resolve_taken;
			rec_rv32c   <= resolve_rv32c;
			rec_mispred <= resolve_taken ^ resolve_pred_taken; // direction wrong
		end
	end

	assign update_valid  = (state == UPDATE);
	assign update_pc     = rec_pc;
	assign update_taken  = rec_taken;
	assign update_target = rec_target; // passed through taken or not

	assign redirect_valid = (state == UPDATE) & rec_mispred;

	// taken goes to the target, else fall past the branch
	always_comb begin
		if (rec_taken) begin
			redirect_pc = rec_target;
		end else begin
			redirect_pc = rec_pc + (rec_rv32c ? 32'd2 : 32'd4);
		end
	end

	// saturating mispredict count
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mispredict_count <= '0;
		end else if (redirect_valid && mispredict_count != '1) begin
			mispredict_count <= mispredict_count + 1'b1;
		end
	end

endmodule

// ==== hw/bpred_top.sv ====
/*
 * Branch prediction front end top level.
 * Connects the fetch PC generator, the BTB and the branch resolver;
 * the testbench drives the decode hints and the execute resolves.
 */
`timescale 1ns/1ps

module bpred_top (
	input  logic                        CLK,
	input  logic                        nRST,
	input  logic                        fetch_en,
	input  logic                        is_branch,  // hint for current fetch_pc
	input  logic                        is_rv32c,
	output bpred_pkg::word_t            fetch_pc,
	output logic                        fetch_valid,
	output logic                        predict_taken,
	input  logic                        resolve_valid,
	input  bpred_pkg::word_t            resolve_pc,
	input  logic                        resolve_taken,
	input  bpred_pkg::word_t            resolve_target,
	input  logic                        resolve_rv32c,
	input  logic                        resolve_pred_taken,
	output logic                        redirect_valid,
	output bpred_pkg::word_t            redirect_pc,
	output bpred_pkg::mispredict_cnt_t  mispredict_count
);
	import bpred_pkg::*;

	word_t target_addr;    // btb next pc into the pc register
	logic  update_valid;   // resolver to btb training
	word_t update_pc;
	logic  update_taken;
	word_t update_target;

	fetch_pc_gen fetch_pc_gen_inst (
		.CLK            (CLK),
		.nRST           (nRST),
		.fetch_en       (fetch_en),
		.target_addr    (target_addr),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.fetch_pc       (fetch_pc),
		.fetch_valid    (fetch_valid)
	);

	btb btb_inst (
		.CLK           (CLK),
		.nRST          (nRST),
		.fetch_pc      (fetch_pc),
		.is_branch     (is_branch),
		.is_rv32c      (is_rv32c),
		.predict_taken (predict_taken),
		.target_addr   (target_addr),
		.update_valid  (update_valid),
		.update_pc     (update_pc),
		.update_taken  (update_taken),
		.update_target (update_target)
	);

	branch_resolver branch_resolver_inst (
		.CLK                (CLK),
		.nRST               (nRST),
		.resolve_valid      (resolve_valid),
		.resolve_pc         (resolve_pc),
		.resolve_taken      (resolve_taken),
		.resolve_target     (resolve_target),
		.resolve_rv32c      (resolve_rv32c),
		.resolve_pred_taken (resolve_pred_taken),
		.update_valid       (update_valid),
		.update_pc          (update_pc),
		.update_taken       (update_taken),
		.update_target      (update_target),
		.redirect_valid     (redirect_valid),
		.redirect_pc        (redirect_pc),
		.mispredict_count   (mispredict_count)
	);

endmodule

// ==== dv/tb_bpred_model.svh ====
/*
 * Reference model for the front end testbench, included in the testbench body.
 * Keeps its own BTB frames, gives the expected next PC and guess for a fetch,
 * and holds the stimulus LFSR.
 */
`ifndef TB_BPRED_MODEL_SVH
`define TB_BPRED_MODEL_SVH

localparam int M_SETS = `BTB_N_FRAMES / `BTB_ASSOC;

// model frames, same tag, target, history layout
btb_tag_t  m_tag    [M_SETS][`BTB_ASSOC];
word_t     m_target [M_SETS][`BTB_ASSOC];
btb_hist_t m_hist   [M_SETS][`BTB_ASSOC];

logic [31:0] lfsr_state = 32'h8ef7_22cf;

function automatic void model_reset();
	for (int s = 0; s < M_SETS; s++) begin
		for (int w = 0; w < `BTB_ASSOC; w++) begin
			m_tag[s][w]    = '0;
			m_target[s][w] = '0;
			m_hist[s][w]   = '0;
		end
	end
endfunction

// expected next fetch pc; pred gets the taken guess
function automatic word_t model_next_pc(input word_t pc, input logic br, input logic c16,
		output logic pred);
	btb_idx_t idx;
	btb_tag_t tag;
	logic     way;
	idx  = pc[`BTB_SET_BITS+1:2];
	tag  = pc[`BTB_SET_BITS+`BTB_TAG_BITS+1:`BTB_SET_BITS+2];
	way  = (m_tag[idx][0] == tag) ? 1'b0 : 1'b1; // frame 0 first
	pred = (m_tag[idx][way] == tag) && br && m_hist[idx][way][`BTB_PRED_BITS-1];
	if (pred) begin
		return m_target[idx][way];
	end
	return c16 ? pc + 32'd2 : pc + 32'd4; // fallthrough
endfunction

// frame 0 on tag match or empty target, else frame 1
function automatic void model_update(input word_t pc, input logic taken, input word_t target);
	btb_idx_t idx;
	btb_tag_t tag;
	logic     way;
	idx = pc[`BTB_SET_BITS+1:2];
	tag = pc[`BTB_SET_BITS+`BTB_TAG_BITS+1:`BTB_SET_BITS+2];
	way = (m_tag[idx][0] == tag || m_target[idx][0] == '0) ? 1'b0 : 1'b1;
	m_tag[idx][way]    = tag;
	m_target[idx][way] = target;
	m_hist[idx][way]   = {m_hist[idx][way][`BTB_PRED_BITS-2:0], taken}; // newest at bit 0
endfunction

// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
function automatic logic next_rand_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], next_rand_bit()};
	end
	return r;
endfunction

`endif

// ==== dv/tb_bpred_top.sv ====
/*
 * Testbench for the branch prediction front end.
 * Directed reset, training, replacement and mispredict sequences, then a random run.
 * A negedge checker tracks the DUT against the reference model every cycle.
 */
`timescale 1ns/1ps
`include "bpred_macros.svh"

module tb_bpred_top;
	import bpred_pkg::*;

	logic            CLK, nRST;
	logic            fetch_en, is_branch, is_rv32c;
	word_t           fetch_pc, resolve_pc, resolve_target, redirect_pc;
	logic            fetch_valid, predict_taken, redirect_valid;
	logic            resolve_valid, resolve_taken, resolve_rv32c, resolve_pred_taken;
	mispredict_cnt_t mispredict_count;

	int    value_errors = 0;
	int    timeout_errors = 0;
	string test_name = "reset";

	// checker state
	word_t           exp_pc, exp_next, exp_redir_pc;
	logic            exp_pred, exp_redir;
	mispredict_cnt_t exp_count, count_before;
	logic            pend_valid, pend_taken, pend_rv32c, pend_mispred; // resolve in flight
	word_t           pend_pc, pend_target;
	word_t           rnd;

	`include "tb_bpred_model.svh"

	bpred_top bpred_top_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input mispredict_cnt_t exp,
			input mispredict_cnt_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#2; // drive point
	endtask

	// one cycle strobe, returns in the update cycle
	task automatic resolve(input word_t pc, input logic taken, input word_t target,
			input logic c16, input logic pred);
		resolve_valid      = 1'b1;
		resolve_pc         = pc;
		resolve_taken      = taken;
		resolve_target     = target;
		resolve_rv32c      = c16;
		resolve_pred_taken = pred;
		next_cycle();
		resolve_valid = 1'b0;
	endtask

	// taken mispredict from set 15 moves fetch to pc
	task automatic steer_to(input word_t pc);
		int n;
		fetch_en = 1'b0;
		resolve(32'h0000_003c, 1'b1, pc, 1'b0, 1'b0);
		next_cycle();
		n = 0;
		while (fetch_pc !== pc && n < 10) begin
			next_cycle();
			n++;
		end
		if (fetch_pc !== pc) begin
			timeout_errors++;
			$display("timed out: fetch_pc never reached %h after a redirect", pc);
		end
	endtask

	// one branch fetch; guess and next pc
	task automatic expect_next(input logic taken, input word_t next_pc);
		is_branch = 1'b1;
		fetch_en  = 1'b1;
		@(negedge CLK);
		check_bit("predict_taken", taken, predict_taken);
		next_cycle();
		fetch_en  = 1'b0;
		is_branch = 1'b0;
		check_word("next fetch_pc", next_pc, fetch_pc);
	endtask

	always @(negedge CLK) begin
		if (nRST !== 1'b1) begin
			model_reset();
			exp_pc     = `BPRED_RESET_PC;
			exp_count  = '0;
			pend_valid = 1'b0;
		end else begin
			exp_next     = model_next_pc(exp_pc, is_branch, is_rv32c, exp_pred);
			exp_redir    = pend_valid && pend_mispred;
			exp_redir_pc = pend_taken ? pend_target : pend_pc + (pend_rv32c ? 32'd2 : 32'd4);
			check_word("fetch_pc", exp_pc, fetch_pc);
			check_bit("predict_taken", exp_pred, predict_taken);
			check_bit("fetch_valid", fetch_en && !exp_redir, fetch_valid);
			check_bit("redirect_valid", exp_redir, redirect_valid);
			if (exp_redir) begin
				check_word("redirect_pc", exp_redir_pc, redirect_pc);
			end
			check_count("mispredict_count", exp_count, mispredict_count);
			// state after the coming edge; lookup above saw the old frames
			if (pend_valid) begin
				model_update(pend_pc, pend_taken, pend_target);
			end
			if (exp_redir) begin
				exp_pc = exp_redir_pc; // redirect wins over fetch_en
				if (exp_count != 16'hffff) begin
					exp_count = exp_count + 16'd1;
				end
			end else if (fetch_en) begin
				exp_pc = exp_next;
			end
			pend_valid   = resolve_valid;
			pend_pc      = resolve_pc;
			pend_target  = resolve_target;
			pend_taken   = resolve_taken;
			pend_rv32c   = resolve_rv32c;
			pend_mispred = resolve_taken != resolve_pred_taken;
		end
	end

	initial begin
		nRST               = 1'b0;
		fetch_en           = 1'b0;
		is_branch          = 1'b0;
		is_rv32c           = 1'b0;
		resolve_valid      = 1'b0;
		resolve_pc         = '0;
		resolve_taken      = 1'b0;
		resolve_target     = '0;
		resolve_rv32c      = 1'b0;
		resolve_pred_taken = 1'b0;
		repeat (2) @(posedge CLK);
		#2;
		nRST = 1'b1;

		@(negedge CLK);
		check_word("reset fetch_pc", `BPRED_RESET_PC, fetch_pc);
		check_bit("reset redirect_valid", 1'b0, redirect_valid);
		check_count("reset count", '0, mispredict_count);
		next_cycle();
		fetch_en = 1'b1; // miss, plain fallthrough
		next_cycle();
		check_word("step 4", `BPRED_RESET_PC + 32'd4, fetch_pc);
		is_rv32c = 1'b1;
		next_cycle();
		check_word("step 2", `BPRED_RESET_PC + 32'd6, fetch_pc);
		is_rv32c = 1'b0;

		test_name = "training";
		steer_to(32'h0000_0200);
		resolve(32'h0000_0200, 1'b1, 32'h0000_0340, 1'b0, 1'b1);
		next_cycle();
		expect_next(1'b0, 32'h0000_0204); // history 01, top bit clear
		steer_to(32'h0000_0200);
		resolve(32'h0000_0200, 1'b1, 32'h0000_0340, 1'b0, 1'b1);
		next_cycle();
		expect_next(1'b1, 32'h0000_0340);

		// tags 1, 2, 3 in set 1; A fills frame 0, B then C take frame 1
		test_name = "replacement";
		resolve(32'h0000_0044, 1'b1, 32'h0000_0600, 1'b0, 1'b1);
		resolve(32'h0000_0044, 1'b1, 32'h0000_0600, 1'b0, 1'b1);
		resolve(32'h0000_0084, 1'b1, 32'h0000_0700, 1'b0, 1'b1);
		resolve(32'h0000_0084, 1'b1, 32'h0000_0700, 1'b0, 1'b1);
		resolve(32'h0000_00c4, 1'b1, 32'h0000_0800, 1'b0, 1'b1);
		resolve(32'h0000_00c4, 1'b1, 32'h0000_0800, 1'b0, 1'b1);
		next_cycle();
		steer_to(32'h0000_0044);
		expect_next(1'b1, 32'h0000_0600);
		steer_to(32'h0000_0084);
		expect_next(1'b0, 32'h0000_0088); // evicted
		steer_to(32'h0000_00c4);
		expect_next(1'b1, 32'h0000_0800);

		test_name = "mispredict";
		count_before = exp_count;
		resolve(32'h0000_00a0, 1'b0, 32'h0000_0500, 1'b1, 1'b1); // not taken, guessed taken
		check_bit("redirect_valid", 1'b1, redirect_valid);
		check_word("redirect_pc", 32'h0000_00a2, redirect_pc);
		next_cycle();
		check_word("fetch_pc", 32'h0000_00a2, fetch_pc);
		check_count("count", count_before + 16'd1, mispredict_count);
		resolve(32'h0000_00a2, 1'b1, 32'h0000_0900, 1'b0, 1'b1); // correct guess
		check_bit("no redirect", 1'b0, redirect_valid);

		test_name = "random";
		for (int i = 0; i < 200; i++) begin
			fetch_en           = next_rand_bit();
			is_branch          = next_rand_bit();
			is_rv32c           = next_rand_bit();
			resolve_valid      = next_rand_bit();
			resolve_taken      = next_rand_bit();
			resolve_rv32c      = next_rand_bit();
			resolve_pred_taken = next_rand_bit();
			rnd = rand_bits(11);
			resolve_target = {19'h0, 1'b1, rnd[10:0], 1'b0}; // never zero
			rnd = rand_bits(11);
			if (next_rand_bit()) begin
				resolve_pc = fetch_pc; // train what is being fetched
			end else begin
				resolve_pc = {20'h0, rnd[10:0], 1'b0};
			end
			next_cycle();
		end
		fetch_en      = 1'b0;
		resolve_valid = 1'b0;
		next_cycle();
		next_cycle();
		check_count("final count", exp_count, mispredict_count);

		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+hw
+incdir+dv
hw/bpred_pkg.sv
hw/fetch_pc_gen.sv
hw/btb.sv
hw/branch_resolver.sv
hw/bpred_top.sv
dv/tb_bpred_top.sv

// ==== Makefile ====
# Verilator build and run for the branch prediction front end

SRCS := $(filter %.sv,$(shell cat flist.f)) hw/bpred_macros.svh dv/tb_bpred_model.svh

obj_dir/Vtb_bpred_top: flist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_bpred_top -Mdir obj_dir -f flist.f

run: obj_dir/Vtb_bpred_top
	@out="$$(./obj_dir/Vtb_bpred_top)"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
